// ==== sources.f ====
+incdir+.
i2c_pkg.sv
i2c_tick_gen.sv
i2c_bit_engine.sv
i2c_txn_fsm.sv
i2c_master.sv
i2c_slave_model.sv
tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the I2C master testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f sources.f \
    --top-module tb_i2c_master \
    -o sim_i2c

./obj_dir/sim_i2c > sim.log
cat sim.log

if grep -q -x "TB PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_i2c_master.sv ====
`timescale 1ns/1ns

`include "i2c_settings.svh"

module tb_i2c_master;

    localparam logic [`I2C_ADDR_WIDTH-1:0] SLAVE_ADDR = 7'h2A;

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_enable;
    logic                       i_rw;
    logic [`I2C_DATA_WIDTH-1:0] i_mosi_data;
    logic [`I2C_DATA_WIDTH-1:0] i_reg_addr;
    logic [`I2C_ADDR_WIDTH-1:0] i_device_addr;
    logic [`I2C_DIV_WIDTH-1:0]  i_divider;
    logic                       i_scl;
    logic                       i_sda;
    logic [`I2C_DATA_WIDTH-1:0] o_miso_data;
    logic                       o_busy;
    logic                       o_nack;
    logic                       o_scl;
    logic                       o_scl_oe;
    logic                       o_sda;
    logic                       o_sda_oe;

    logic                       scl_master;
    logic                       sda_master;
    logic                       scl_pull;
    logic                       sda_pull;
    logic                       stretch_en;
    logic                       stretch_all;
    logic [15:0]                stop_count;

    // Reference register file
    logic [`I2C_DATA_WIDTH-1:0] ref_regs [logic [7:0]];

    int checks;
    int errors;
    int test_checks;
    int test_errors;
    int tests_done;
    bit timed_out;

    // Open-drain bus
    assign scl_master = o_scl_oe ? o_scl : 1'b1;
    assign sda_master = o_sda_oe ? o_sda : 1'b1;
    assign i_scl      = scl_master & !scl_pull;
    assign i_sda      = sda_master & !sda_pull;

    i2c_master u_dut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_enable      (i_enable),
        .i_rw          (i_rw),
        .i_mosi_data   (i_mosi_data),
        .i_reg_addr    (i_reg_addr),
        .i_device_addr (i_device_addr),
        .i_divider     (i_divider),
        .i_scl         (i_scl),
        .i_sda         (i_sda),
        .o_miso_data   (o_miso_data),
        .o_busy        (o_busy),
        .o_nack        (o_nack),
        .o_scl         (o_scl),
        .o_scl_oe      (o_scl_oe),
        .o_sda         (o_sda),
        .o_sda_oe      (o_sda_oe)
    );

    i2c_slave_model u_slave (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_dev_addr    (SLAVE_ADDR),
        .i_stretch_en  (stretch_en),
        .i_stretch_all (stretch_all),
        .i_scl_master  (scl_master),
        .i_scl         (i_scl),
        .i_sda         (i_sda),
        .o_scl_pull    (scl_pull),
        .o_sda_pull    (sda_pull),
        .o_stop_count  (stop_count)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check(input bit ok, input string what);
        if (!timed_out) begin
            checks++;
            test_checks++;
            assert (ok) else begin
                $display("mismatch at %0t ns: %s", $time, what);
                errors++;
                test_errors++;
            end
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic wait_busy(input logic level, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (o_busy !== level && cnt < limit) begin
            @(negedge i_clk);
            cnt++;
        end
        if (o_busy !== level) begin
            $display("timeout at %0t ns: o_busy did not %s within %0d cycles",
                     $time, what, limit);
            timed_out = 1'b1;
        end
    endtask

    task automatic run_txn(input logic rw, input logic [`I2C_ADDR_WIDTH-1:0] dev,
                           input logic [7:0] reg_a, input logic [7:0] data, input int div);
        int bit_cycles;
        bit_cycles = `I2C_BIT_PHASES * (div + 1);
        @(negedge i_clk);
        i_divider     = 16'(div);
        i_rw          = rw;
        i_device_addr = dev;
        i_reg_addr    = reg_a;
        i_mosi_data   = data;
        i_enable      = 1'b1;
        wait_busy(1'b1, bit_cycles + 8, "rise");
        i_enable = 1'b0;
        // Longest transaction is 39 bit units and stretch adds up to 21 clocks to each
        if (!timed_out) begin
            wait_busy(1'b0, 48 * (bit_cycles + 32), "fall");
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [7:0]  r;
        logic [7:0]  d;
        logic [7:0]  exp;
        logic [7:0]  prev;
        logic [15:0] stops;
        logic        rw;
        int          div;

        void'($urandom(86));
        i_rst         = 1'b1;
        i_enable      = 1'b0;
        i_rw          = 1'b0;
        i_mosi_data   = '0;
        i_reg_addr    = '0;
        i_device_addr = '0;
        i_divider     = 16'd4;
        stretch_en    = 1'b0;
        stretch_all   = 1'b0;
        checks        = 0;
        errors        = 0;
        test_checks   = 0;
        test_errors   = 0;
        tests_done    = 0;
        timed_out     = 1'b0;
        repeat (16) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);

        // Reference starts from the device's power-up image
        for (int a = 0; a < 256; a++) begin
            ref_regs[a[7:0]] = u_slave.regs[a[7:0]];
        end

        check(o_busy == 1'b0, "o_busy high after reset");
        check(o_nack == 1'b0, "o_nack high after reset");
        check(o_miso_data == 8'h00, $sformatf("o_miso_data %02h after reset", o_miso_data));
        check(o_scl_oe && o_sda_oe && o_scl && o_sda,
              $sformatf("pins after reset scl %b/%b sda %b/%b",
                        o_scl, o_scl_oe, o_sda, o_sda_oe));
        check(i_scl == 1'b1 && i_sda == 1'b1, "bus lines not idle high after reset");
        report_test("reset_state");

        stretch_en = 1'b1;
        for (int n = 0; n < 40 && !timed_out; n++) begin
            r     = 8'($urandom_range(255, 0));
            d     = 8'($urandom_range(255, 0));
            div   = int'($urandom_range(9, 2));
            stops = stop_count;
            run_txn(1'b0, SLAVE_ADDR, r, d, div);
            ref_regs[r] = d;
            check(!o_busy && !o_nack, $sformatf("write %0d busy %b nack %b", n, o_busy, o_nack));
            check(u_slave.regs[r] == ref_regs[r], $sformatf("reg %02h holds %02h expected %02h",
                  r, u_slave.regs[r], ref_regs[r]));
            check(stop_count == stops + 16'd1, $sformatf("write %0d stop count %0d from %0d",
                  n, stop_count, stops));
        end
        report_test("random_writes");

        for (int n = 0; n < 40 && !timed_out; n++) begin
            r     = 8'($urandom_range(255, 0));
            div   = int'($urandom_range(9, 2));
            exp   = ref_regs[r];
            stops = stop_count;
            run_txn(1'b1, SLAVE_ADDR, r, 8'h00, div);
            check(o_miso_data == exp, $sformatf("read reg %02h got %02h expected %02h",
                  r, o_miso_data, exp));
            check(!o_nack, $sformatf("read %0d flagged nack", n));
            check(stop_count == stops + 16'd1, $sformatf("read %0d stop count %0d from %0d",
                  n, stop_count, stops));
        end
        report_test("random_reads");

        for (int n = 0; n < 4 && !timed_out; n++) begin
            r     = 8'($urandom_range(255, 0));
            d     = 8'($urandom_range(255, 0));
            div   = int'($urandom_range(9, 2));
            rw    = n[0];
            prev  = o_miso_data;
            stops = stop_count;
            run_txn(rw, SLAVE_ADDR ^ 7'($urandom_range(127, 1)), r, d, div);
            check(o_nack, $sformatf("wrong address %0d not flagged", n));
            check(stop_count == stops, $sformatf("wrong address %0d sent a stop", n));
            check(o_miso_data == prev, $sformatf("o_miso_data changed to %02h from %02h",
                  o_miso_data, prev));
            for (int a = 0; a < 256; a++) begin
                check(u_slave.regs[a[7:0]] == ref_regs[a[7:0]],
                      $sformatf("reg %02h changed by wrong address", a));
            end
        end
        report_test("wrong_address");

        stretch_all = 1'b1;
        for (int n = 0; n < 40 && !timed_out; n++) begin
            rw  = 1'($urandom_range(1, 0));
            r   = 8'($urandom_range(255, 0));
            d   = 8'($urandom_range(255, 0));
            div = int'($urandom_range(9, 2));
            exp = ref_regs[r];
            run_txn(rw, SLAVE_ADDR, r, d, div);
            check(!o_nack, $sformatf("mixed %0d flagged nack", n));
            if (rw) begin
                check(o_miso_data == exp, $sformatf("stretched read reg %02h got %02h expected %02h",
                      r, o_miso_data, exp));
            end else begin
                ref_regs[r] = d;
                check(u_slave.regs[r] == d, $sformatf("stretched write reg %02h holds %02h",
                      r, u_slave.regs[r]));
            end
        end
        report_test("stretch_mixed");

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (timed_out || errors != 0) begin
            $display("TB FAILED");
        end else begin
            $display("TB PASSED");
        end
        $finish;
    end

endmodule

// ==== i2c_slave_model.sv ====
`timescale 1ns/1ns

`include "i2c_settings.svh"

module i2c_slave_model (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic [`I2C_ADDR_WIDTH-1:0] i_dev_addr,
    input  logic                       i_stretch_en,
    input  logic                       i_stretch_all,
    input  logic                       i_scl_master,
    input  logic                       i_scl,
    input  logic                       i_sda,
    output logic                       o_scl_pull,
    output logic                       o_sda_pull,
    output logic [15:0]                o_stop_count
);

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_START,
        SL_DEV,
        SL_REG,
        SL_WDATA,
        SL_RDATA
    } slave_state_t;

    logic [`I2C_DATA_WIDTH-1:0] regs [0:255];
    slave_state_t               state;
    logic                       scl_d;
    logic                       sda_d;
    logic [3:0]                 bit_cnt;
    logic [`I2C_DATA_WIDTH-1:0] shift_q;
    logic [`I2C_DATA_WIDTH-1:0] tx_q;
    logic [`I2C_DATA_WIDTH-1:0] ptr;
    logic                       rw_q;
    logic [4:0]                 stretch_cnt;
    logic                       start_cond;
    logic                       stop_cond;
    logic                       scl_rise;
    logic                       scl_fall;

    assign start_cond = scl_d && i_scl && sda_d && !i_sda;
    assign stop_cond  = scl_d && i_scl && !sda_d && i_sda;
    assign scl_rise   = !scl_d && i_scl;
    assign scl_fall   = scl_d && !i_scl;

    //////////////////////////////
    // Protocol decode
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            // Power-up image with every entry distinct
            for (int i = 0; i < 256; i++) begin
                regs[i[7:0]] <= 8'(i * 37) ^ 8'h5A;
            end
            state        <= SL_IDLE;
            scl_d        <= 1'b1;
            sda_d        <= 1'b1;
            bit_cnt      <= 4'd0;
            shift_q      <= '0;
            tx_q         <= '0;
            ptr          <= '0;
            rw_q         <= 1'b0;
            o_sda_pull   <= 1'b0;
            o_stop_count <= 16'd0;
        end else begin
            scl_d <= i_scl;
            sda_d <= i_sda;
            if (start_cond) begin
                state      <= SL_START;
                bit_cnt    <= 4'd0;
                o_sda_pull <= 1'b0;
            end else if (stop_cond) begin
                state        <= SL_IDLE;
                o_sda_pull   <= 1'b0;
                o_stop_count <= o_stop_count + 16'd1;
            end else if (scl_fall && state == SL_START) begin
                // SCL fall that closes the start condition
                state <= SL_DEV;
            end else if (scl_rise && state != SL_IDLE && bit_cnt < 4'd8) begin
                shift_q <= {shift_q[`I2C_DATA_WIDTH-2:0], i_sda};
            end else if (scl_fall && state != SL_IDLE) begin
                if (bit_cnt < 4'd7) begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (state == SL_RDATA) begin
                        o_sda_pull <= !tx_q[3'd6 - bit_cnt[2:0]];
                    end
                end else if (bit_cnt == 4'd7) begin
                    // Acknowledge slot follows
                    bit_cnt <= 4'd8;
                    case (state)
                        SL_DEV: begin
                            if (shift_q[7:1] == i_dev_addr) begin
                                o_sda_pull <= 1'b1;
                                rw_q       <= shift_q[0];
                            end else begin
                                state <= SL_IDLE;
                            end
                        end
                        SL_REG: begin
                            ptr        <= shift_q;
                            o_sda_pull <= 1'b1;
                        end
                        SL_WDATA: begin
                            regs[ptr]  <= shift_q;
                            ptr        <= ptr + 8'd1;
                            o_sda_pull <= 1'b1;
                        end
                        default: begin
                            o_sda_pull <= 1'b0;
                        end
                    endcase
                end else begin
                    bit_cnt    <= 4'd0;
                    o_sda_pull <= 1'b0;
                    case (state)
                        SL_DEV: begin
                            if (rw_q) begin
                                state      <= SL_RDATA;
                                tx_q       <= regs[ptr];
                                o_sda_pull <= !regs[ptr][7];
                            end else begin
                                state <= SL_REG;
                            end
                        end
                        SL_REG:   state <= SL_WDATA;
                        SL_RDATA: state <= SL_IDLE;
                        default:  state <= state;
                    endcase
                end
            end
        end
    end

    //////////////////////////////
    // Clock stretching
    //////////////////////////////

    // Hold SCL after it falls and count only once the master has let go
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_scl_pull  <= 1'b0;
            stretch_cnt <= 5'd0;
        end else if (o_scl_pull) begin
            if (i_scl_master) begin
                if (stretch_cnt == 5'd0) begin
                    o_scl_pull <= 1'b0;
                end else begin
                    stretch_cnt <= stretch_cnt - 5'd1;
                end
            end
        end else if (scl_fall && state != SL_IDLE && i_stretch_en) begin
            if (i_stretch_all || $urandom_range(1, 0) == 1) begin
                o_scl_pull  <= 1'b1;
                stretch_cnt <= 5'($urandom_range(20, 0));
            end
        end
    end

endmodule

// ==== i2c_master.sv ====
`timescale 1ns/1ns

`include "i2c_settings.svh"

module i2c_master
    import i2c_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_enable,
    input  logic                       i_rw,
    input  logic [`I2C_DATA_WIDTH-1:0] i_mosi_data,
    input  logic [`I2C_DATA_WIDTH-1:0] i_reg_addr,
    input  logic [`I2C_ADDR_WIDTH-1:0] i_device_addr,
    input  logic [`I2C_DIV_WIDTH-1:0]  i_divider,
    input  logic                       i_scl,
    input  logic                       i_sda,
    output logic [`I2C_DATA_WIDTH-1:0] o_miso_data,
    output logic                       o_busy,
    output logic                       o_nack,
    output logic                       o_scl,
    output logic                       o_scl_oe,
    output logic                       o_sda,
    output logic                       o_sda_oe
);

    logic                       tick;
    logic                       cmd_valid;
    bit_cmd_t                   cmd;
    logic [`I2C_DATA_WIDTH-1:0] tx_byte;
    logic                       done;
    logic                       ack_ok;
    logic [`I2C_DATA_WIDTH-1:0] rx_byte;

    i2c_tick_gen u_tick_gen (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_divider (i_divider),
        .o_tick    (tick)
    );

    i2c_txn_fsm u_txn_fsm (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_tick        (tick),
        .i_enable      (i_enable),
        .i_rw          (i_rw),
        .i_device_addr (i_device_addr),
        .i_reg_addr    (i_reg_addr),
        .i_mosi_data   (i_mosi_data),
        .i_done        (done),
        .i_ack_ok      (ack_ok),
        .i_rx_byte     (rx_byte),
        .o_cmd_valid   (cmd_valid),
        .o_cmd         (cmd),
        .o_tx_byte     (tx_byte),
        .o_busy        (o_busy),
        .o_nack        (o_nack),
        .o_miso_data   (o_miso_data)
    );

    i2c_bit_engine u_bit_engine (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_tick      (tick),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .i_tx_byte   (tx_byte),
        .i_scl       (i_scl),
        .i_sda       (i_sda),
        .o_done      (done),
        .o_ack_ok    (ack_ok),
        .o_rx_byte   (rx_byte),
        .o_scl       (o_scl),
        .o_scl_oe    (o_scl_oe),
        .o_sda       (o_sda),
        .o_sda_oe    (o_sda_oe)
    );

endmodule

// ==== i2c_txn_fsm.sv ====
`timescale 1ns/1ns

`include "i2c_settings.svh"

module i2c_txn_fsm
    import i2c_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_tick,
    input  logic                       i_enable,
    input  logic                       i_rw,
    input  logic [`I2C_ADDR_WIDTH-1:0] i_device_addr,
    input  logic [`I2C_DATA_WIDTH-1:0] i_reg_addr,
    input  logic [`I2C_DATA_WIDTH-1:0] i_mosi_data,
    input  logic                       i_done,
    input  logic                       i_ack_ok,
    input  logic [`I2C_DATA_WIDTH-1:0] i_rx_byte,
    output logic                       o_cmd_valid,
    output bit_cmd_t                   o_cmd,
    output logic [`I2C_DATA_WIDTH-1:0] o_tx_byte,
    output logic                       o_busy,
    output logic                       o_nack,
    output logic [`I2C_DATA_WIDTH-1:0] o_miso_data
);

    txn_state_t                 state;
    logic                       cmd_sent;
    logic                       accept;
    logic                       rw_q;
    logic [`I2C_ADDR_WIDTH-1:0] dev_q;
    logic [`I2C_DATA_WIDTH-1:0] reg_q;
    logic [`I2C_DATA_WIDTH-1:0] data_q;

    assign accept      = (state == S_IDLE) && i_tick && i_enable;
    assign o_busy      = (state != S_IDLE);

    // One strobe per state, on the first cycle in it
    assign o_cmd_valid = o_busy && !cmd_sent;

    //////////////////////////////
    // Command decode
    //////////////////////////////

    always_comb begin
        o_cmd     = CMD_WRITE;
        o_tx_byte = data_q;
        case (state)
            S_START: begin
                o_cmd = CMD_START;
            end
            S_RESTART: begin
                o_cmd = CMD_RESTART;
            end
            S_DATA_R: begin
                o_cmd = CMD_READ;
            end
            S_STOP: begin
                o_cmd = CMD_STOP;
            end
            S_DEV_W: begin
                o_tx_byte = {dev_q, 1'b0};
            end
            S_DEV_R: begin
                o_tx_byte = {dev_q, 1'b1};
            end
            S_REG_ADDR: begin
                o_tx_byte = reg_q;
            end
            default: begin
                o_tx_byte = data_q;
            end
        endcase
    end

    // Operands held for the whole transaction
    always_ff @(posedge i_clk) begin
        if (accept) begin
            rw_q   <= i_rw;
            dev_q  <= i_device_addr;
            reg_q  <= i_reg_addr;
            data_q <= i_mosi_data;
        end
    end

    //////////////////////////////
    // Transaction FSM
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= S_IDLE;
            cmd_sent    <= 1'b0;
            o_nack      <= 1'b0;
            o_miso_data <= '0;
        end else begin
            if (o_cmd_valid) begin
                cmd_sent <= 1'b1;
            end
            if (accept) begin
                state  <= S_START;
                o_nack <= 1'b0;
            end else if (i_done && cmd_sent) begin
                cmd_sent <= 1'b0;
                case (state)
                    S_START:    state <= S_DEV_W;
                    S_DEV_W:    state <= S_REG_ADDR;
                    S_REG_ADDR: state <= rw_q ? S_RESTART : S_DATA_W;
                    S_DATA_W:   state <= S_STOP;
                    S_RESTART:  state <= S_DEV_R;
                    S_DEV_R:    state <= S_DATA_R;
                    S_DATA_R: begin
                        state       <= S_STOP;
                        o_miso_data <= i_rx_byte;
                    end
                    default:    state <= S_IDLE;
                endcase
                // Every written byte must be acknowledged, else abort
                if (o_cmd == CMD_WRITE && !i_ack_ok) begin
                    state  <= S_IDLE;
                    o_nack <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== i2c_bit_engine.sv ====
`timescale 1ns/1ns

`include "i2c_settings.svh"

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_tick,
    input  logic                       i_cmd_valid,
    input  bit_cmd_t                   i_cmd,
    input  logic [`I2C_DATA_WIDTH-1:0] i_tx_byte,
    input  logic                       i_scl,
    input  logic                       i_sda,
    output logic                       o_done,
    output logic                       o_ack_ok,
    output logic [`I2C_DATA_WIDTH-1:0] o_rx_byte,
    output logic                       o_scl,
    output logic                       o_scl_oe,
    output logic                       o_sda,
    output logic                       o_sda_oe
);

    localparam int PH_W  = $clog2(`I2C_BIT_PHASES);
    localparam int BIT_W = $clog2(`I2C_DATA_WIDTH + 1);

    // SDA setup with SCL low, SCL released, SCL high, SCL falls
    localparam logic [PH_W-1:0] PH_SETUP = PH_W'(0);
    localparam logic [PH_W-1:0] PH_RISE  = PH_W'(1);
    localparam logic [PH_W-1:0] PH_HIGH  = PH_W'(2);
    localparam logic [PH_W-1:0] PH_FALL  = PH_W'(`I2C_BIT_PHASES - 1);

    logic                       busy;
    bit_cmd_t                   cmd_q;
    logic [PH_W-1:0]            phase;
    logic [BIT_W-1:0]           bit_cnt;
    logic [`I2C_DATA_WIDTH-1:0] shift_q;
    logic                       last_unit;
    logic                       nack_bit;
    logic                       scl_q;
    logic                       sda_q;
    logic                       sda_oe_q;

    // Byte commands run 8 data bits plus one ACK/NACK bit
    assign last_unit = (bit_cnt == '0);
    assign nack_bit  = (cmd_q == CMD_WRITE) && last_unit && !o_ack_ok;

    assign o_rx_byte = shift_q;
    assign o_scl     = scl_q;
    assign o_sda     = sda_q;
    assign o_sda_oe  = sda_oe_q;

    // Released in phase 1 so a stretching device can hold SCL low
    assign o_scl_oe  = !(busy && phase == PH_RISE);

    //////////////////////////////
    // Phase sequencer
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy     <= 1'b0;
            cmd_q    <= CMD_START;
            phase    <= PH_SETUP;
            bit_cnt  <= '0;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            sda_oe_q <= 1'b1;
            o_done   <= 1'b0;
            o_ack_ok <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (!busy) begin
                if (i_cmd_valid) begin
                    busy     <= 1'b1;
                    cmd_q    <= i_cmd;
                    phase    <= PH_SETUP;
                    o_ack_ok <= 1'b0;
                    if (i_cmd == CMD_WRITE || i_cmd == CMD_READ) begin
                        bit_cnt <= BIT_W'(`I2C_DATA_WIDTH);
                    end else begin
                        bit_cnt <= '0;
                    end
                end
            end else if (i_tick) begin
                case (phase)
                    PH_SETUP: begin
                        phase <= PH_RISE;
                        case (cmd_q)
                            CMD_START, CMD_RESTART: begin
                                sda_q    <= 1'b1;
                                sda_oe_q <= 1'b1;
                            end
                            CMD_STOP: begin
                                sda_q    <= 1'b0;
                                sda_oe_q <= 1'b1;
                            end
                            CMD_WRITE: begin
                                sda_q    <= shift_q[`I2C_DATA_WIDTH-1];
                                sda_oe_q <= !last_unit;
                            end
                            CMD_READ: begin
                                // Last bit is the NACK
                                sda_q    <= 1'b1;
                                sda_oe_q <= last_unit;
                            end
                            default: begin
                                sda_oe_q <= 1'b1;
                            end
                        endcase
                    end
                    PH_RISE: begin
                        // Wait out clock stretching
                        if (i_scl) begin
                            scl_q <= 1'b1;
                            phase <= PH_HIGH;
                        end
                    end
                    PH_HIGH: begin
                        phase <= PH_FALL;
                        case (cmd_q)
                            CMD_START, CMD_RESTART: begin
                                sda_q <= 1'b0;
                            end
                            CMD_STOP: begin
                                sda_q <= 1'b1;
                            end
                            CMD_WRITE: begin
                                if (last_unit) begin
                                    o_ack_ok <= !i_sda;
                                end
                            end
                            default: begin
                                sda_q <= sda_q;
                            end
                        endcase
                    end
                    PH_FALL: begin
                        phase <= PH_SETUP;
                        // After a stop or a refused byte SCL stays high
                        if (cmd_q != CMD_STOP && !nack_bit) begin
                            scl_q <= 1'b0;
                        end
                        // SDA is already high from the NACK, so no stop
                        if (nack_bit) begin
                            sda_q    <= 1'b1;
                            sda_oe_q <= 1'b1;
                        end
                        if (last_unit) begin
                            busy   <= 1'b0;
                            o_done <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                    default: begin
                        phase <= PH_SETUP;
                    end
                endcase
            end
        end
    end

    //////////////////////////////
    // Data shift register
    //////////////////////////////

    // Shifts in the sampled SDA for writes too, so the MSB is always next
    always_ff @(posedge i_clk) begin
        if (!busy && i_cmd_valid) begin
            shift_q <= i_tx_byte;
        end else if (busy && i_tick && phase == PH_HIGH && !last_unit) begin
            shift_q <= {shift_q[`I2C_DATA_WIDTH-2:0], i_sda};
        end
    end

endmodule

// ==== i2c_tick_gen.sv ====
`timescale 1ns/1ns

`include "i2c_settings.svh"

module i2c_tick_gen (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic [`I2C_DIV_WIDTH-1:0] i_divider,
    output logic                      o_tick
);

    logic [`I2C_DIV_WIDTH-1:0] div_cnt;

    // Terminal count, also catches a divider lowered below the count
    assign o_tick = (div_cnt >= i_divider);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            div_cnt <= '0;
        end else if (o_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// ==== i2c_pkg.sv ====
package i2c_pkg;

    //////////////////////////////
    // Bit engine opcodes
    //////////////////////////////

    typedef enum logic [2:0] {
        CMD_START,
        CMD_RESTART,
        CMD_WRITE,
        CMD_READ,
        CMD_STOP
    } bit_cmd_t;

    //////////////////////////////
    // Transaction states
    //////////////////////////////

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_DEV_W,
        S_REG_ADDR,
        S_DATA_W,
        S_RESTART,
        S_DEV_R,
        S_DATA_R,
        S_STOP
    } txn_state_t;

endpackage

// ==== i2c_settings.svh ====
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// Register address and data byte
`define I2C_DATA_WIDTH 8

// 7-bit device address, R/W bit appended on the wire
`define I2C_ADDR_WIDTH 7

// Tick divider input
`define I2C_DIV_WIDTH 16

//////////////////////////////
// Bit timing
//////////////////////////////

// Ticks per SCL bit
`define I2C_BIT_PHASES 4

`endif
